// File: verilog/issue_pkg.sv
// Issue subsystem definitions
// Register, tag and word widths, the lane select, the lane depths and
// the bit layout of a raw instruction word
`default_nettype none

package issue_pkg;

  // Each register file holds this many registers, one scalar and one vector file
  localparam int NUM_REGISTERS = 64;
  localparam int REG_IDX_W = 6;
  localparam int ID_W = 8;
  localparam int WORD_W = 36;

  typedef logic [REG_IDX_W-1:0] register_idx_t;

  // Scoreboard index, the top bit selects the vector file
  typedef logic [REG_IDX_W:0] ext_register_idx_t;

  // Program tag that follows an instruction all the way to writeback
  typedef logic [ID_W-1:0] instr_id_t;

  typedef logic [WORD_W-1:0] instr_word_t;

  // Execution lane of an instruction
  typedef enum logic {
    PIPE_INT = 1'b0,
    PIPE_MEM = 1'b1
  } pipeline_sel_t;

  // Issue to retire depth of each lane
  localparam int INT_LATENCY = 3;
  localparam int MEM_LATENCY = 4;

  // The longest lane decides how far back a rollback has to reach
  localparam int ROLLBACK_STAGES = MEM_LATENCY;

  // Instruction word layout, bits 35 and 34 are spare
  localparam int ID_LSB = 0;
  localparam int HAS_DEST_BIT = 8;
  localparam int DEST_VECTOR_BIT = 9;
  localparam int PIPE_MEM_BIT = 10;
  localparam int BRANCH_TAKEN_BIT = 11;
  localparam int DEST_LSB = 12;

  // First source operand
  localparam int HAS_SRC1_BIT = 18;
  localparam int SRC1_VECTOR_BIT = 19;
  localparam int SRC1_LSB = 20;

  // Second source operand
  localparam int HAS_SRC2_BIT = 26;
  localparam int SRC2_VECTOR_BIT = 27;
  localparam int SRC2_LSB = 28;

endpackage

`default_nettype wire

// File: verilog/issue_if.sv
// Issue subsystem interfaces
// decode_if carries the decoded head instruction to the scoreboard and
// retire_if carries writebacks and rollbacks out of the execution lanes
`default_nettype none

interface decode_if import issue_pkg::*; ();
  logic has_dest;
  logic dest_vector;
  register_idx_t dest_reg;
  logic has_src1;
  logic src1_vector;
  register_idx_t src1_reg;
  logic has_src2;
  logic src2_vector;
  register_idx_t src2_reg;
  logic will_issue;
  logic can_issue;

  // The issue stage decodes and decides, the scoreboard answers with can_issue
  modport issuer(output has_dest, dest_vector, dest_reg, has_src1, src1_vector, src1_reg,
                 has_src2, src2_vector, src2_reg, will_issue, input can_issue);
  modport scorer(input has_dest, dest_vector, dest_reg, has_src1, src1_vector, src1_reg,
                 has_src2, src2_vector, src2_reg, will_issue, output can_issue);
endinterface

interface retire_if import issue_pkg::*; #(
  parameter int QUEUE_DEPTH = 8,
  localparam int SLOT_W = $clog2(QUEUE_DEPTH)
) ();
  logic wb_valid;
  logic wb_vector;
  register_idx_t wb_reg;
  instr_id_t wb_id;
  logic rollback_en;
  pipeline_sel_t rollback_pipe;
  logic [SLOT_W-1:0] rollback_slot;

  modport producer(output wb_valid, wb_vector, wb_reg, wb_id, rollback_en, rollback_pipe,
                   rollback_slot);
  modport consumer(input wb_valid, wb_vector, wb_reg, wb_id, rollback_en, rollback_pipe,
                   rollback_slot);
endinterface

`default_nettype wire

// File: verilog/instruction_queue.sv
// Replay instruction queue
// Circular buffer whose slots stay held after issue until the instruction
// can no longer be rolled back, so squashed work issues again from here
`default_nettype none

module instruction_queue import issue_pkg::*; #(
  parameter int QUEUE_DEPTH = 8,
  localparam int SLOT_W = $clog2(QUEUE_DEPTH)
) (
  input wire clk,
  input wire reset,
  input wire in_valid,
  input wire instr_word_t in_word,
  input wire will_issue,
  output logic in_ready,
  output logic head_valid,
  output instr_word_t head_word,
  output logic [SLOT_W-1:0] head_slot,
  retire_if.consumer retire
);
  // Pointers carry one extra wrap bit to tell a full buffer from an empty one
  typedef logic [SLOT_W:0] ptr_t;
  localparam int LAST = ROLLBACK_STAGES - 1;

  instr_word_t slots [QUEUE_DEPTH];
  ptr_t wr_ptr;
  ptr_t iss_ptr;
  ptr_t rel_ptr;
  ptr_t rel_ptr_nxt;
  logic [ROLLBACK_STAGES-1:0] win_valid;
  logic [ROLLBACK_STAGES-1:0] win_keep;
  logic [SLOT_W-1:0] rewind_slot;
  logic full;
  logic accept;

  // Held slots run from the release pointer up to the write pointer
  assign full = (wr_ptr[SLOT_W] != rel_ptr[SLOT_W])
      && (wr_ptr[SLOT_W-1:0] == rel_ptr[SLOT_W-1:0]);
  assign in_ready = !full;
  assign accept = in_valid && in_ready;

  // Words between the issue and write pointers still wait for issue
  assign head_valid = iss_ptr != wr_ptr;
  assign head_slot = iss_ptr[SLOT_W-1:0];
  assign head_word = slots[head_slot];

  assign rewind_slot = retire.rollback_slot + 1'b1;

  // The window records one bit per cycle for the last ROLLBACK_STAGES issues
  // A rollback drops every entry younger than the branch
  // An integer branch still sits in the oldest entry and retires normally
  always_comb
  begin
    win_keep = win_valid;
    if (retire.rollback_en)
    begin
      win_keep[LAST-1:0] = '0;
      if (retire.rollback_pipe == PIPE_MEM)
        win_keep[LAST] = 1'b0;
    end
  end

  // Issues leave the window in slot order, so releasing is a pointer step
  assign rel_ptr_nxt = rel_ptr + win_keep[LAST];

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      iss_ptr <= '0;
      rel_ptr <= '0;
      win_valid <= '0;
    end
    else
    begin
      if (accept)
        wr_ptr <= wr_ptr + 1'b1;
      rel_ptr <= rel_ptr_nxt;
      win_valid <= {win_keep[LAST-1:0], will_issue};
      // After a rollback the slot after the branch is also the oldest held one
      if (retire.rollback_en)
        iss_ptr <= {rel_ptr_nxt[SLOT_W], rewind_slot};
      else if (will_issue)
        iss_ptr <= iss_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      slots[wr_ptr[SLOT_W-1:0]] <= in_word;
  end

endmodule

`default_nettype wire

// File: verilog/issue_stage.sv
// In-order issue stage
// Decodes the queue head for the scoreboard and issues it once no
// register hazard, lane conflict or rollback is in the way
`default_nettype none

module issue_stage import issue_pkg::*; #(
  parameter int QUEUE_DEPTH = 8,
  localparam int SLOT_W = $clog2(QUEUE_DEPTH)
) (
  input wire clk,
  input wire reset,
  input wire head_valid,
  input wire instr_word_t head_word,
  input wire [SLOT_W-1:0] head_slot,
  decode_if.issuer dec,
  retire_if.consumer retire,
  output logic will_issue,
  output instr_word_t iss_word,
  output logic [SLOT_W-1:0] iss_slot
);
  pipeline_sel_t head_pipe;
  logic mem_last;
  logic lane_hazard;

  // Field split of the head word
  assign dec.has_dest = head_word[HAS_DEST_BIT];
  assign dec.dest_vector = head_word[DEST_VECTOR_BIT];
  assign dec.dest_reg = head_word[DEST_LSB +: REG_IDX_W];
  assign dec.has_src1 = head_word[HAS_SRC1_BIT];
  assign dec.src1_vector = head_word[SRC1_VECTOR_BIT];
  assign dec.src1_reg = head_word[SRC1_LSB +: REG_IDX_W];
  assign dec.has_src2 = head_word[HAS_SRC2_BIT];
  assign dec.src2_vector = head_word[SRC2_VECTOR_BIT];
  assign dec.src2_reg = head_word[SRC2_LSB +: REG_IDX_W];

  assign head_pipe = pipeline_sel_t'(head_word[PIPE_MEM_BIT]);

  // The memory lane is one stage deeper, so an integer op issued right
  // behind a memory op would reach writeback in the same cycle
  assign lane_hazard = mem_last && (head_pipe == PIPE_INT);

  // Nothing issues while a rollback rewinds the queue
  assign will_issue = head_valid && dec.can_issue && !retire.rollback_en && !lane_hazard;
  assign dec.will_issue = will_issue;

  // The pipeline captures the head on the edge that ends the issue cycle
  assign iss_word = head_word;
  assign iss_slot = head_slot;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      mem_last <= 1'b0;
    else
      mem_last <= will_issue && (head_pipe == PIPE_MEM);
  end

endmodule

`default_nettype wire

// File: verilog/scoreboard.sv
// Register scoreboard
// Tracks a busy bit for each of the 128 scalar and vector registers and
// blocks issue on read-after-write and write-after-write hazards
`default_nettype none

module scoreboard import issue_pkg::*; (
  input wire clk,
  input wire reset,
  decode_if.scorer dec,
  retire_if.consumer retire
);
  localparam int ENTRIES = 2 * NUM_REGISTERS;
  localparam int LAST = ROLLBACK_STAGES - 1;

  typedef logic [ENTRIES-1:0] bitmap_t;

  bitmap_t busy;
  bitmap_t busy_nxt;
  bitmap_t dest_mask;
  bitmap_t dep_mask;
  bitmap_t wb_mask;
  bitmap_t squash_mask;
  ext_register_idx_t dest_idx;

  // Destinations issued over the last ROLLBACK_STAGES cycles, newest at 0
  logic [ROLLBACK_STAGES-1:0] hist_valid;
  logic [ROLLBACK_STAGES-2:0] hist_shift;
  ext_register_idx_t hist_reg [ROLLBACK_STAGES];

  // One-hot mask for a single register, empty when en is low
  function automatic bitmap_t reg_bit(input logic en, input ext_register_idx_t idx);
    bitmap_t mask;
    mask = '0;
    mask[idx] = en;
    return mask;
  endfunction

  assign dest_idx = {dec.dest_vector, dec.dest_reg};
  assign dest_mask = reg_bit(dec.has_dest, dest_idx);

  // The destination joins the sources so that a second writer waits for the first
  assign dep_mask = dest_mask
      | reg_bit(dec.has_src1, {dec.src1_vector, dec.src1_reg})
      | reg_bit(dec.has_src2, {dec.src2_vector, dec.src2_reg});

  assign dec.can_issue = (busy & dep_mask) == '0;

  assign wb_mask = reg_bit(retire.wb_valid, {retire.wb_vector, retire.wb_reg});

  // In the rollback cycle the three newest entries are always younger
  // than the branch
  // The oldest entry is the integer branch itself, or a squashed
  // instruction when the branch came from the deeper memory lane
  always_comb
  begin
    squash_mask = '0;
    if (retire.rollback_en)
    begin
      for (int i = 0; i < LAST; i++)
        squash_mask = squash_mask | reg_bit(hist_valid[i], hist_reg[i]);
      if (retire.rollback_pipe == PIPE_MEM)
        squash_mask = squash_mask | reg_bit(hist_valid[LAST], hist_reg[LAST]);
    end
  end

  // Squashed entries leave the history so that they are never cleared twice
  assign hist_shift = retire.rollback_en ? '0 : hist_valid[LAST-1:0];

  // A bit freed by writeback or rollback is free again in the next cycle
  assign busy_nxt = (busy & ~(wb_mask | squash_mask))
      | (dest_mask & {ENTRIES{dec.will_issue}});

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      busy <= '0;
      hist_valid <= '0;
    end
    else
    begin
      busy <= busy_nxt;
      hist_valid <= {hist_shift, dec.will_issue && dec.has_dest};
    end
  end

  // Register numbers are only looked at where the matching valid bit is set
  always_ff @(posedge clk)
  begin
    hist_reg[0] <= dest_idx;
    for (int i = 1; i < ROLLBACK_STAGES; i++)
      hist_reg[i] <= hist_reg[i-1];
  end

endmodule

`default_nettype wire

// File: verilog/execution_pipeline.sv
// Two-lane execution model
// Integer and memory ops flow through fixed-depth stage chains and
// retire from a registered writeback port
// A retiring taken branch raises rollback and squashes younger stages
`default_nettype none

module execution_pipeline import issue_pkg::*; #(
  parameter int QUEUE_DEPTH = 8,
  localparam int SLOT_W = $clog2(QUEUE_DEPTH)
) (
  input wire clk,
  input wire reset,
  input wire will_issue,
  input wire instr_word_t iss_word,
  input wire [SLOT_W-1:0] iss_slot,
  retire_if.producer retire
);
  // Wide enough for every instruction that can be in flight at once
  localparam int ORDER_W = 4;

  typedef logic [ORDER_W-1:0] order_t;
  typedef logic [SLOT_W-1:0] slot_t;

  logic [INT_LATENCY-1:0] int_valid;
  logic [INT_LATENCY-1:0] int_live;
  instr_word_t int_word [INT_LATENCY];
  slot_t int_slot [INT_LATENCY];
  order_t int_order [INT_LATENCY];

  logic [MEM_LATENCY-1:0] mem_valid;
  logic [MEM_LATENCY-1:0] mem_live;
  instr_word_t mem_word [MEM_LATENCY];
  slot_t mem_slot [MEM_LATENCY];
  order_t mem_order [MEM_LATENCY];

  order_t issue_order;
  order_t wb_order;
  pipeline_sel_t iss_pipe;

  logic ret_valid;
  instr_word_t ret_word;
  slot_t ret_slot;
  order_t ret_order;
  pipeline_sel_t ret_pipe;

  // Issue order compared modulo the tag width
  function automatic logic younger(input order_t tag, input order_t branch);
    order_t diff;
    diff = tag - branch;
    return (diff != '0) && !diff[ORDER_W-1];
  endfunction

  assign iss_pipe = pipeline_sel_t'(iss_word[PIPE_MEM_BIT]);

  // During a rollback cycle every stage younger than the branch is dropped
  always_comb
  begin
    for (int i = 0; i < INT_LATENCY; i++)
      int_live[i] = int_valid[i] && !(retire.rollback_en && younger(int_order[i], wb_order));
    for (int i = 0; i < MEM_LATENCY; i++)
      mem_live[i] = mem_valid[i] && !(retire.rollback_en && younger(mem_order[i], wb_order));
  end

  // The issue lane rule keeps both chain ends from being live together
  always_comb
  begin
    ret_valid = int_live[INT_LATENCY-1] || mem_live[MEM_LATENCY-1];
    if (int_live[INT_LATENCY-1])
    begin
      ret_word = int_word[INT_LATENCY-1];
      ret_slot = int_slot[INT_LATENCY-1];
      ret_order = int_order[INT_LATENCY-1];
      ret_pipe = PIPE_INT;
    end
    else
    begin
      ret_word = mem_word[MEM_LATENCY-1];
      ret_slot = mem_slot[MEM_LATENCY-1];
      ret_order = mem_order[MEM_LATENCY-1];
      ret_pipe = PIPE_MEM;
    end
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      int_valid <= '0;
      mem_valid <= '0;
      issue_order <= '0;
      retire.wb_valid <= 1'b0;
      retire.rollback_en <= 1'b0;
    end
    else
    begin
      int_valid <= {int_live[INT_LATENCY-2:0], will_issue && (iss_pipe == PIPE_INT)};
      mem_valid <= {mem_live[MEM_LATENCY-2:0], will_issue && (iss_pipe == PIPE_MEM)};
      if (will_issue)
        issue_order <= issue_order + 1'b1;
      // Only instructions with a destination produce a writeback
      retire.wb_valid <= ret_valid && ret_word[HAS_DEST_BIT];
      retire.rollback_en <= ret_valid && ret_word[BRANCH_TAKEN_BIT];
    end
  end

  // Stage payload moves every cycle and is qualified by the valid chains
  always_ff @(posedge clk)
  begin
    int_word[0] <= iss_word;
    int_slot[0] <= iss_slot;
    int_order[0] <= issue_order;
    for (int i = 1; i < INT_LATENCY; i++)
    begin
      int_word[i] <= int_word[i-1];
      int_slot[i] <= int_slot[i-1];
      int_order[i] <= int_order[i-1];
    end
    mem_word[0] <= iss_word;
    mem_slot[0] <= iss_slot;
    mem_order[0] <= issue_order;
    for (int i = 1; i < MEM_LATENCY; i++)
    begin
      mem_word[i] <= mem_word[i-1];
      mem_slot[i] <= mem_slot[i-1];
      mem_order[i] <= mem_order[i-1];
    end
    retire.wb_vector <= ret_word[DEST_VECTOR_BIT];
    retire.wb_reg <= ret_word[DEST_LSB +: REG_IDX_W];
    retire.wb_id <= ret_word[ID_LSB +: ID_W];
    retire.rollback_pipe <= ret_pipe;
    retire.rollback_slot <= ret_slot;
    wb_order <= ret_order;
  end

endmodule

`default_nettype wire

// File: verilog/issue_unit.sv
// Issue subsystem top
// Joins the replay queue, issue stage, scoreboard and execution lanes
// and presents writeback and rollback as plain ports
`default_nettype none

module issue_unit import issue_pkg::*; #(
  parameter int QUEUE_DEPTH = 8,
  localparam int SLOT_W = $clog2(QUEUE_DEPTH)
) (
  input wire clk,
  input wire reset,
  input wire instr_valid,
  input wire instr_word_t instr_word,
  output logic instr_ready,
  output logic wb_valid,
  output logic wb_vector,
  output register_idx_t wb_reg,
  output instr_id_t wb_id,
  output logic rollback
);
  logic head_valid;
  instr_word_t head_word;
  logic [SLOT_W-1:0] head_slot;
  logic will_issue;
  instr_word_t iss_word;
  logic [SLOT_W-1:0] iss_slot;

  decode_if dec_bus ();
  retire_if #(.QUEUE_DEPTH(QUEUE_DEPTH)) ret_bus ();

  instruction_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) queue_inst (
    .clk(clk),
    .reset(reset),
    .in_valid(instr_valid),
    .in_word(instr_word),
    .will_issue(will_issue),
    .in_ready(instr_ready),
    .head_valid(head_valid),
    .head_word(head_word),
    .head_slot(head_slot),
    .retire(ret_bus.consumer)
  );

  issue_stage #(.QUEUE_DEPTH(QUEUE_DEPTH)) issue_inst (
    .clk(clk),
    .reset(reset),
    .head_valid(head_valid),
    .head_word(head_word),
    .head_slot(head_slot),
    .dec(dec_bus.issuer),
    .retire(ret_bus.consumer),
    .will_issue(will_issue),
    .iss_word(iss_word),
    .iss_slot(iss_slot)
  );

  scoreboard scoreboard_inst (
    .clk(clk),
    .reset(reset),
    .dec(dec_bus.scorer),
    .retire(ret_bus.consumer)
  );

  execution_pipeline #(.QUEUE_DEPTH(QUEUE_DEPTH)) pipeline_inst (
    .clk(clk),
    .reset(reset),
    .will_issue(will_issue),
    .iss_word(iss_word),
    .iss_slot(iss_slot),
    .retire(ret_bus.producer)
  );

  // Retire port of the design
  assign wb_valid = ret_bus.wb_valid;
  assign wb_vector = ret_bus.wb_vector;
  assign wb_reg = ret_bus.wb_reg;
  assign wb_id = ret_bus.wb_id;
  assign rollback = ret_bus.rollback_en;

endmodule

`default_nettype wire

// File: bench/issue_properties.sv
// Issue rule assertions
// Bound into the issue unit to watch issue decisions, the lane rule and
// the scoreboard state at writeback
`default_nettype none

module issue_properties import issue_pkg::*; (
  input wire clk,
  input wire reset,
  input wire will_issue,
  input wire instr_word_t head_word,
  input wire head_mem,
  input wire wb_valid,
  input wire wb_vector,
  input wire register_idx_t wb_reg,
  input wire [2*NUM_REGISTERS-1:0] busy
);
  // Running total of assertion failures, read back at the end of the run
  int failures = 0;

  logic dep_busy;

  // Some register that the head word reads or writes is still in flight
  assign dep_busy = (head_word[HAS_DEST_BIT]
      && busy[{head_word[DEST_VECTOR_BIT], head_word[DEST_LSB +: REG_IDX_W]}])
      || (head_word[HAS_SRC1_BIT]
      && busy[{head_word[SRC1_VECTOR_BIT], head_word[SRC1_LSB +: REG_IDX_W]}])
      || (head_word[HAS_SRC2_BIT]
      && busy[{head_word[SRC2_VECTOR_BIT], head_word[SRC2_LSB +: REG_IDX_W]}]);

  // An instruction only leaves the queue when none of its registers is busy
  issue_needs_clear: assert property (@(posedge clk) disable iff (reset)
      will_issue |-> !dep_busy)
  else
  begin
    failures++;
    $error("issue while a register of the head instruction is busy");
  end

  // A memory issue keeps the integer lane closed for one cycle
  int_after_mem: assert property (@(posedge clk) disable iff (reset)
      (will_issue && head_mem) |=> !(will_issue && !head_mem))
  else
  begin
    failures++;
    $error("integer issue in the cycle after a memory issue");
  end

  // The busy bit stays set until the edge that ends the writeback cycle
  wb_targets_busy: assert property (@(posedge clk) disable iff (reset)
      wb_valid |-> busy[{wb_vector, wb_reg}])
  else
  begin
    failures++;
    $error("writeback to a register that is not marked busy");
  end

endmodule

`default_nettype wire

// File: bench/issue_monitor.sv
// Writeback monitor
// Watches the retire port and compares each writeback and rollback with
// the expected retire record of the program
`default_nettype none

module issue_monitor import issue_pkg::*; (
  input wire clk,
  input wire reset,
  input wire wb_valid,
  input wire wb_vector,
  input wire register_idx_t wb_reg,
  input wire instr_id_t wb_id,
  input wire rollback
);
  localparam int NUM_IDS = 2 ** ID_W;
  localparam int ENTRIES = 2 * NUM_REGISTERS;

  // Expected record, filled by the testbench before reset is released
  logic exp_has_dest [NUM_IDS];
  ext_register_idx_t exp_dest [NUM_IDS];
  int exp_rank [NUM_IDS];
  int exp_writebacks;
  int exp_rollbacks;

  // What the DUT has produced so far
  logic seen [NUM_IDS];
  int writes_seen [ENTRIES];
  int wb_total = 0;
  int rollback_count = 0;

  // Error counts, one per check
  int err_once = 0;
  int err_dest = 0;
  int err_order = 0;
  int err_rollback = 0;

  // Each id must retire once, to its own register, in its writer slot
  task automatic check_writeback();
    ext_register_idx_t actual;
    ext_register_idx_t expected;
    actual = {wb_vector, wb_reg};
    expected = exp_dest[wb_id];
    wb_total++;
    if (!exp_has_dest[wb_id])
    begin
      err_once++;
      $display("writeback_once: id %0d has no destination but was written back", wb_id);
    end
    else if (seen[wb_id])
    begin
      err_once++;
      $display("writeback_once: id %0d was written back more than once", wb_id);
    end
    else
    begin
      seen[wb_id] = 1'b1;
      if (actual != expected)
      begin
        err_dest++;
        $display("FAIL writeback_dest id %0d expected vector %0d reg %0d actual vector %0d reg %0d",
                 wb_id, expected[REG_IDX_W], expected[REG_IDX_W-1:0], wb_vector, wb_reg);
      end
      // Position among the writers of the same register, in program order
      if (writes_seen[expected] != exp_rank[wb_id])
      begin
        err_order++;
        $display("FAIL writer_order id %0d expected position %0d actual position %0d",
                 wb_id, exp_rank[wb_id], writes_seen[expected]);
      end
      writes_seen[expected]++;
    end
  endtask

  // Called once the DUT has gone quiet
  task automatic finish_checks();
    for (int i = 0; i < NUM_IDS; i++)
    begin
      if (exp_has_dest[i] && !seen[i])
      begin
        err_once++;
        $display("writeback_once: id %0d was never written back", i);
      end
    end
    if (rollback_count != exp_rollbacks)
    begin
      err_rollback++;
      $display("FAIL rollback_count expected %0d actual %0d", exp_rollbacks, rollback_count);
    end
  endtask

  // Outputs change on the rising edge, so the falling edge sees them settled
  always @(negedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < NUM_IDS; i++)
        seen[i] = 1'b0;
      for (int r = 0; r < ENTRIES; r++)
        writes_seen[r] = 0;
      wb_total = 0;
      rollback_count = 0;
    end
    else
    begin
      if (wb_valid)
        check_writeback();
      if (rollback)
        rollback_count++;
    end
  end

endmodule

`default_nettype wire

// File: bench/issue_unit_tb.sv
// Issue unit testbench
// Feeds a random program with idle gaps and dense bursts, then reports
// each check once the writebacks have drained
`default_nettype none

module issue_unit_tb;
  import issue_pkg::*;

  localparam int NUM_WORDS = 256;
  localparam int REG_POOL = 4;
  localparam int BURST_LEN = 32;
  localparam int RESET_CYCLES = 5;
  localparam int ACCEPT_TIMEOUT = 500;
  localparam int DRAIN_TIMEOUT = 4000;
  localparam int QUIET_CYCLES = 24;
  localparam int QUIET_TIMEOUT = 400;
  localparam logic [31:0] SEED = 32'h5a54_43ae;

  logic clk = 1'b0;
  logic reset;
  logic instr_valid;
  instr_word_t instr_word;
  logic instr_ready;
  logic wb_valid;
  logic wb_vector;
  register_idx_t wb_reg;
  instr_id_t wb_id;
  logic rollback;

  instr_word_t program_words [NUM_WORDS];
  logic timed_out;
  int stalls;
  int accepted;
  int tests_run;
  int tests_failed;

  always #20 clk = ~clk;

  issue_unit #(.QUEUE_DEPTH(8)) issue_unit_inst (
    .clk(clk),
    .reset(reset),
    .instr_valid(instr_valid),
    .instr_word(instr_word),
    .instr_ready(instr_ready),
    .wb_valid(wb_valid),
    .wb_vector(wb_vector),
    .wb_reg(wb_reg),
    .wb_id(wb_id),
    .rollback(rollback)
  );

  issue_monitor monitor_inst (
    .clk(clk),
    .reset(reset),
    .wb_valid(wb_valid),
    .wb_vector(wb_vector),
    .wb_reg(wb_reg),
    .wb_id(wb_id),
    .rollback(rollback)
  );

  bind issue_unit issue_properties props_inst (
    .clk(clk),
    .reset(reset),
    .will_issue(will_issue),
    .head_word(head_word),
    .head_mem(head_word[issue_pkg::PIPE_MEM_BIT]),
    .wb_valid(wb_valid),
    .wb_vector(wb_vector),
    .wb_reg(wb_reg),
    .busy(scoreboard_inst.busy)
  );

  // A small pool keeps hazards between neighbours frequent
  function automatic register_idx_t pick_register();
    return register_idx_t'($urandom % REG_POOL);
  endfunction

  task automatic build_program();
    instr_word_t word;
    for (int i = 0; i < NUM_WORDS; i++)
    begin
      word = '0;
      word[ID_LSB +: ID_W] = instr_id_t'(i);
      word[HAS_DEST_BIT] = ($urandom % 8) != 0;
      word[DEST_VECTOR_BIT] = ($urandom % 2) == 1;
      word[PIPE_MEM_BIT] = ($urandom % 3) == 0;
      word[BRANCH_TAKEN_BIT] = ($urandom % 12) == 0;
      word[DEST_LSB +: REG_IDX_W] = pick_register();
      word[HAS_SRC1_BIT] = ($urandom % 4) != 0;
      word[SRC1_VECTOR_BIT] = ($urandom % 2) == 1;
      word[SRC1_LSB +: REG_IDX_W] = pick_register();
      word[HAS_SRC2_BIT] = ($urandom % 3) != 0;
      word[SRC2_VECTOR_BIT] = ($urandom % 2) == 1;
      word[SRC2_LSB +: REG_IDX_W] = pick_register();
      program_words[i] = word;
    end
  endtask

  // Expected retire record from the program alone: one writeback per
  // destination, writers of a register ranked in program order, and one
  // rollback per taken branch
  function automatic void expected_retire();
    int writers [2*NUM_REGISTERS];
    ext_register_idx_t dest;
    instr_id_t id;
    logic has_dest;
    monitor_inst.exp_writebacks = 0;
    monitor_inst.exp_rollbacks = 0;
    for (int r = 0; r < 2 * NUM_REGISTERS; r++)
      writers[r] = 0;
    for (int i = 0; i < NUM_WORDS; i++)
    begin
      id = program_words[i][ID_LSB +: ID_W];
      has_dest = program_words[i][HAS_DEST_BIT];
      dest = {program_words[i][DEST_VECTOR_BIT], program_words[i][DEST_LSB +: REG_IDX_W]};
      monitor_inst.exp_has_dest[id] = has_dest;
      monitor_inst.exp_dest[id] = dest;
      monitor_inst.exp_rank[id] = writers[dest];
      if (has_dest)
      begin
        writers[dest]++;
        monitor_inst.exp_writebacks++;
      end
      if (program_words[i][BRANCH_TAKEN_BIT])
        monitor_inst.exp_rollbacks++;
    end
  endfunction

  // Odd stretches of the program get idle gaps, even ones run back to back
  task automatic insert_gap(input int index);
    int gap;
    gap = 0;
    if ((index / BURST_LEN) % 2 == 1 && ($urandom % 3) == 0)
      gap = 1 + $urandom % 4;
    if (gap > 0)
    begin
      instr_valid <= 1'b0;
      repeat (gap) @(posedge clk);
    end
  endtask

  // The word is held until an edge sees instr_ready high
  task automatic send_word(input instr_word_t word);
    int waited;
    waited = 0;
    instr_valid <= 1'b1;
    instr_word <= word;
    @(posedge clk);
    while (!instr_ready && !timed_out)
    begin
      stalls++;
      waited++;
      if (waited >= ACCEPT_TIMEOUT)
      begin
        timed_out = 1'b1;
        $display("input word was not accepted within %0d cycles", ACCEPT_TIMEOUT);
      end
      else
        @(posedge clk);
    end
    if (!timed_out)
      accepted++;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (!timed_out && (monitor_inst.wb_total < monitor_inst.exp_writebacks
        || monitor_inst.rollback_count < monitor_inst.exp_rollbacks))
    begin
      @(posedge clk);
      waited++;
      if (waited >= DRAIN_TIMEOUT)
      begin
        timed_out = 1'b1;
        $display("writebacks did not finish within %0d cycles", DRAIN_TIMEOUT);
      end
    end
  endtask

  // Late duplicates would show up during this quiet stretch
  task automatic wait_quiet();
    int waited;
    int quiet;
    waited = 0;
    quiet = 0;
    while (!timed_out && quiet < QUIET_CYCLES)
    begin
      @(posedge clk);
      waited++;
      if (wb_valid || rollback)
        quiet = 0;
      else
        quiet++;
      if (waited >= QUIET_TIMEOUT && quiet < QUIET_CYCLES)
      begin
        timed_out = 1'b1;
        $display("retire port did not go quiet within %0d cycles", QUIET_TIMEOUT);
      end
    end
  endtask

  task automatic report_test(input string name, input int errors);
    tests_run++;
    if (errors != 0)
      tests_failed++;
    $display("test %s %s with %0d errors", name, (errors == 0) ? "passed" : "failed", errors);
  endtask

  initial
  begin
    int bp_errors;
    reset = 1'b1;
    instr_valid = 1'b0;
    instr_word = '0;
    timed_out = 1'b0;
    stalls = 0;
    accepted = 0;
    tests_run = 0;
    tests_failed = 0;
    bp_errors = 0;
    void'($urandom(SEED));
    build_program();
    expected_retire();
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    for (int i = 0; i < NUM_WORDS && !timed_out; i++)
    begin
      insert_gap(i);
      send_word(program_words[i]);
    end
    instr_valid <= 1'b0;
    wait_drain();
    wait_quiet();
    monitor_inst.finish_checks();
    if (stalls == 0)
    begin
      bp_errors++;
      $display("input_backpressure: instr_ready never fell under sustained input");
    end
    if (accepted != NUM_WORDS)
    begin
      bp_errors++;
      $display("input_backpressure: only %0d of %0d words were accepted", accepted, NUM_WORDS);
    end
    if (timed_out)
      bp_errors++;
    report_test("writeback_once", monitor_inst.err_once);
    report_test("writeback_dest", monitor_inst.err_dest);
    report_test("writer_order", monitor_inst.err_order);
    report_test("rollback_count", monitor_inst.err_rollback);
    report_test("input_backpressure", bp_errors);
    report_test("issue_rules", issue_unit_inst.props_inst.failures);
    $display("%0d tests run, %0d passed, %0d failed", tests_run, tests_run - tests_failed,
             tests_failed);
    if (timed_out || tests_failed != 0)
      $display("SIMULATION FAILED");
    else
      $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
verilog/issue_pkg.sv
verilog/issue_if.sv
verilog/instruction_queue.sv
verilog/issue_stage.sv
verilog/scoreboard.sv
verilog/execution_pipeline.sv
verilog/issue_unit.sv
bench/issue_properties.sv
bench/issue_monitor.sv
bench/issue_unit_tb.sv

// File: Bender.yml
package:
  name: issue_unit

sources:
  - files:
      - verilog/issue_pkg.sv
      - verilog/issue_if.sv
      - verilog/instruction_queue.sv
      - verilog/issue_stage.sv
      - verilog/scoreboard.sv
      - verilog/execution_pipeline.sv
      - verilog/issue_unit.sv
  - target: test
    files:
      - bench/issue_properties.sv
      - bench/issue_monitor.sv
      - bench/issue_unit_tb.sv
